//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing -Wno-fatal -f ramIfPortUnit.f \
		--top-module ramIfPortUnitTb -Mdir obj_dir
	./obj_dir/VramIfPortUnitTb | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- design/hyperBusSequencer.sv
//--------------------
// stage 2: hyperbus FSM for cs, ck, CA shift,
// latency wait, write bytes and read capture
//--------------------
module hyperBusSequencer
	import ramIfPortPkg::*;
#(
	parameter int pRamDqWidth = 8,
	parameter int pLatencyClocks = 6
)(
	input  logic clk,
	input  logic arstN,
	input  ramReqT req,
	input  logic reqVd,
	output logic reqRdy,
	input  logic [31:0] wrWord,
	input  logic wrVd,
	output logic wrRdy,
	output logic [pRamDqWidth-1:0] dqOut,
	input  logic [pRamDqWidth-1:0] dqIn,
	output logic dqOe,
	output logic rwdsOut,
	input  logic rwdsIn,
	output logic rwdsOe,
	output logic ckP,
	output logic ckN,
	output logic csN,
	output logic ramRstN,
	output rdByteT rdByte,
	output logic rdByteVd
);

	localparam int lpLatW = $clog2(2 * pLatencyClocks);
	localparam logic [2:0] lpIdle = 3'd0;
	localparam logic [2:0] lpCs = 3'd1;
	localparam logic [2:0] lpCa = 3'd2;
	localparam logic [2:0] lpLat = 3'd3;
	localparam logic [2:0] lpWr = 3'd4;
	localparam logic [2:0] lpRd = 3'd5;

	logic [2:0] state;
	logic [47:0] ca;
	logic [47:0] caNext;
	logic [2:0] caCnt;
	logic [lpLatW-1:0] latCnt;
	// rwds seen high during CA
	logic dblLat;
	logic isRd;
	logic [6:0] byteLeft;
	// byte position inside the current write word
	logic [1:0] byteIdx;
	logic [31:0] wrBuf;
	// one ck edge in the middle of each cycle it is set
	logic ckRun;
	logic rwdsPrev;
	logic rdCap;
	logic [1:0] rstDly;

	// CA word from the request
	always_comb begin
		caNext = '0;
		caNext[caRdWrBit] = req.rdWr;
		caNext[caAsBit] = req.addrSpace;
		caNext[caBurstBit] = req.burstLinear;
		caNext[caRowHi:caRowLo] = {8'd0, req.wordAddr[23:3]};
		caNext[caColHi:0] = req.wordAddr[2:0];
	end

	assign reqRdy = (state == lpIdle);
	assign wrRdy = (state == lpWr) && (byteIdx == 2'd0) && (byteLeft != 7'd0);
	// device latches rwds edges, a new byte per change
	assign rdCap = (state == lpRd) && (rwdsIn != rwdsPrev);
	// no byte masking
	assign rwdsOut = 1'b0;
	assign ckN = ~ckP;
	assign ramRstN = rstDly[1];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rstDly <= 2'b00;
		end else begin
			rstDly <= {rstDly[0], 1'b1};
		end
	end

	// ck edges sit half a cycle after dq changes
	always_ff @(negedge clk or negedge arstN) begin
		if (!arstN) begin
			ckP <= 1'b0;
		end else if (ckRun) begin
			ckP <= ~ckP;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= lpIdle;
			csN <= 1'b1;
			dqOe <= 1'b0;
			rwdsOe <= 1'b0;
			ckRun <= 1'b0;
			caCnt <= 3'd0;
			latCnt <= '0;
			dblLat <= 1'b0;
			isRd <= 1'b0;
			byteLeft <= 7'd0;
			byteIdx <= 2'd0;
			rwdsPrev <= 1'b0;
			rdByteVd <= 1'b0;
		end else begin
			rwdsPrev <= rwdsIn;
			rdByteVd <= rdCap;
			case (state)
				lpIdle: begin
					if (reqVd) begin
						isRd <= req.rdWr;
						byteLeft <= req.byteCnt;
						state <= lpCs;
					end
				end
				lpCs: begin
					// first CA byte goes out with cs low
					csN <= 1'b0;
					dqOe <= 1'b1;
					ckRun <= 1'b1;
					caCnt <= 3'd5;
					dblLat <= 1'b0;
					state <= lpCa;
				end
				lpCa: begin
					dblLat <= dblLat | rwdsIn;
					if (caCnt != 3'd0) begin
						caCnt <= caCnt - 3'd1;
					end else begin
						dqOe <= 1'b0;
						latCnt <= (dblLat | rwdsIn) ? lpLatW'(2 * pLatencyClocks - 1)
							: lpLatW'(pLatencyClocks - 1);
						state <= lpLat;
					end
				end
				lpLat: begin
					if (latCnt != '0) begin
						latCnt <= latCnt - 1'b1;
					end else if (isRd) begin
						state <= lpRd;
					end else begin
						// clock waits for the first write word
						ckRun <= 1'b0;
						dqOe <= 1'b1;
						rwdsOe <= 1'b1;
						byteIdx <= 2'd0;
						state <= lpWr;
					end
				end
				lpWr: begin
					if (byteLeft == 7'd0) begin
						csN <= 1'b1;
						dqOe <= 1'b0;
						rwdsOe <= 1'b0;
						ckRun <= 1'b0;
						state <= lpIdle;
					end else if (byteIdx == 2'd0) begin
						// stalled word holds ck and cs
						ckRun <= wrVd;
						if (wrVd) begin
							byteIdx <= 2'd1;
							byteLeft <= byteLeft - 7'd1;
						end
					end else begin
						ckRun <= 1'b1;
						byteIdx <= byteIdx + 2'd1;
						byteLeft <= byteLeft - 7'd1;
					end
				end
				lpRd: begin
					if (rdCap) begin
						byteLeft <= byteLeft - 7'd1;
						if (byteLeft == 7'd1) begin
							csN <= 1'b1;
							ckRun <= 1'b0;
							state <= lpIdle;
						end
					end
				end
				default: state <= lpIdle;
			endcase
		end
	end

	// dq payload and captured byte
	always_ff @(posedge clk) begin
		case (state)
			lpIdle: begin
				if (reqVd) begin
					ca <= caNext;
				end
			end
			lpCs, lpCa: begin
				dqOut <= ca[47 -: pRamDqWidth];
				ca <= ca << pRamDqWidth;
			end
			lpWr: begin
				if (wrVd && wrRdy) begin
					// most significant byte first
					dqOut <= wrWord[31 -: pRamDqWidth];
					wrBuf <= wrWord << pRamDqWidth;
				end else if (byteIdx != 2'd0) begin
					dqOut <= wrBuf[31 -: pRamDqWidth];
					wrBuf <= wrBuf << pRamDqWidth;
				end
			end
			default: begin
			end
		endcase
		rdByte.data <= dqIn;
		rdByte.last <= (byteLeft == 7'd1);
	end

endmodule

//--- design/ramIfPortPkg.sv
//--------------------
// shared types of the hyperram port unit:
// ufib header/word, request, read byte, CA bit map
//--------------------
package ramIfPortPkg;

	// CA word bit map, 48 bits shifted msb first
	localparam int caRdWrBit = 47;
	localparam int caAsBit = 46;
	localparam int caBurstBit = 45;
	// row/col field, upper word address bits
	localparam int caRowHi = 44;
	localparam int caRowLo = 16;
	// lower column, word address bits 2..0
	localparam int caColHi = 2;

	// header word of a ufib packet
	typedef struct packed {
		// 1 read, 0 write
		logic rdWr;
		// 1 register space
		logic addrSpace;
		// 1 linear, 0 wrapped
		logic burstLinear;
		// words per burst, 0 means 1
		logic [4:0] burstLen;
		logic [23:0] wordAddr;
	} ufibHdrT;

	// same port word, header or payload depending on decoder state
	typedef union packed {
		ufibHdrT hdr;
		logic [31:0] data;
	} ufibWordU;

	// request handed from decoder to sequencer
	typedef struct packed {
		logic rdWr;
		logic addrSpace;
		logic burstLinear;
		// burst length times four
		logic [6:0] byteCnt;
		logic [23:0] wordAddr;
	} ramReqT;

	// one byte captured on dq in a read
	typedef struct packed {
		logic [7:0] data;
		logic last;
	} rdByteT;

endpackage

//--- design/ramIfPortUnit.sv
//--------------------
// hyperram port unit top:
// decoder, bus sequencer, read packer
//--------------------
module ramIfPortUnit
	import ramIfPortPkg::*;
#(
	parameter int pRamDqWidth = 8,
	parameter int pLatencyClocks = 6
)(
	input  logic clk,
	input  logic arstN,
	// ufib write port
	input  ufibWordU wd,
	input  logic wdVd,
	output logic wdRdy,
	// read port, no back-pressure
	output logic [31:0] rd,
	output logic rdVd,
	// hyperbus pins
	output logic [pRamDqWidth-1:0] dqOut,
	input  logic [pRamDqWidth-1:0] dqIn,
	output logic dqOe,
	output logic rwdsOut,
	input  logic rwdsIn,
	output logic rwdsOe,
	output logic ckP,
	output logic ckN,
	output logic csN,
	output logic ramRstN
);

	ramReqT req;
	logic reqVd;
	logic reqRdy;
	logic [31:0] wrWord;
	logic wrVd;
	logic wrRdy;
	rdByteT rdByte;
	logic rdByteVd;

	ufibPacketDecoder uDecoder (
		.clk(clk),
		.arstN(arstN),
		.wd(wd),
		.wdVd(wdVd),
		.wdRdy(wdRdy),
		.req(req),
		.reqVd(reqVd),
		.reqRdy(reqRdy),
		.wrWord(wrWord),
		.wrVd(wrVd),
		.wrRdy(wrRdy)
	);

	hyperBusSequencer #(
		.pRamDqWidth(pRamDqWidth),
		.pLatencyClocks(pLatencyClocks)
	) uSequencer (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.reqVd(reqVd),
		.reqRdy(reqRdy),
		.wrWord(wrWord),
		.wrVd(wrVd),
		.wrRdy(wrRdy),
		.dqOut(dqOut),
		.dqIn(dqIn),
		.dqOe(dqOe),
		.rwdsOut(rwdsOut),
		.rwdsIn(rwdsIn),
		.rwdsOe(rwdsOe),
		.ckP(ckP),
		.ckN(ckN),
		.csN(csN),
		.ramRstN(ramRstN),
		.rdByte(rdByte),
		.rdByteVd(rdByteVd)
	);

	readWordPacker uPacker (
		.clk(clk),
		.arstN(arstN),
		.rdByte(rdByte),
		.rdByteVd(rdByteVd),
		.rd(rd),
		.rdVd(rdVd)
	);

endmodule

//--- design/readWordPacker.sv
//--------------------
// stage 3: read bytes into 32-bit words,
// msb first, realigned on the last byte
//--------------------
module readWordPacker
	import ramIfPortPkg::*;
(
	input  logic clk,
	input  logic arstN,
	input  rdByteT rdByte,
	input  logic rdByteVd,
	output logic [31:0] rd,
	output logic rdVd
);

	// bytes collected so far in the current word
	logic [1:0] byteCnt;
	// upper three bytes waiting for the fourth
	logic [23:0] acc;
	logic wordDone;

	// fourth byte, or burst end
	assign wordDone = rdByteVd && ((byteCnt == 2'd3) || rdByte.last);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			byteCnt <= 2'd0;
			rdVd <= 1'b0;
		end else begin
			rdVd <= wordDone;
			if (wordDone) begin
				// next burst starts on a word boundary
				byteCnt <= 2'd0;
			end else if (rdByteVd) begin
				byteCnt <= byteCnt + 2'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rdByteVd) begin
			acc <= {acc[15:0], rdByte.data};
		end
		if (wordDone) begin
			rd <= {acc, rdByte.data};
		end
	end

endmodule

//--- design/ufibPacketDecoder.sv
//--------------------
// stage 1: ufib header decode,
// request hand-off and write word pass-through
//--------------------
module ufibPacketDecoder
	import ramIfPortPkg::*;
(
	input  logic clk,
	input  logic arstN,
	input  ufibWordU wd,
	input  logic wdVd,
	output logic wdRdy,
	output ramReqT req,
	output logic reqVd,
	input  logic reqRdy,
	output logic [31:0] wrWord,
	output logic wrVd,
	input  logic wrRdy
);

	localparam logic [1:0] lpHdr = 2'd0;
	localparam logic [1:0] lpReq = 2'd1;
	localparam logic [1:0] lpWrData = 2'd2;

	logic [1:0] state;
	// holds wdRdy low for the first cycle out of reset
	logic rdyEn;
	// write words still to pass, minus one
	logic [4:0] wordLeft;
	logic [4:0] hdrLen;
	logic hdrTake;

	// zero length is taken as a single word
	assign hdrLen = (wd.hdr.burstLen == 5'd0) ? 5'd1 : wd.hdr.burstLen;
	assign hdrTake = (state == lpHdr) && rdyEn && wdVd;

	assign wdRdy = ((state == lpHdr) && rdyEn) || ((state == lpWrData) && wrRdy);
	assign reqVd = (state == lpReq);
	// data phase, port word read as plain payload
	assign wrWord = wd.data;
	assign wrVd = (state == lpWrData) && wdVd;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= lpHdr;
			rdyEn <= 1'b0;
			wordLeft <= 5'd0;
		end else begin
			rdyEn <= 1'b1;
			case (state)
				lpHdr: begin
					if (hdrTake) begin
						wordLeft <= hdrLen - 5'd1;
						state <= lpReq;
					end
				end
				lpReq: begin
					// reads carry no payload
					if (reqRdy) begin
						state <= req.rdWr ? lpHdr : lpWrData;
					end
				end
				lpWrData: begin
					if (wdVd && wrRdy) begin
						if (wordLeft == 5'd0) begin
							state <= lpHdr;
						end else begin
							wordLeft <= wordLeft - 5'd1;
						end
					end
				end
				default: state <= lpHdr;
			endcase
		end
	end

	// request payload, latched with the header
	always_ff @(posedge clk) begin
		if (hdrTake) begin
			req.rdWr <= wd.hdr.rdWr;
			req.addrSpace <= wd.hdr.addrSpace;
			req.burstLinear <= wd.hdr.burstLinear;
			req.byteCnt <= {hdrLen, 2'b00};
			req.wordAddr <= wd.hdr.wordAddr;
		end
	end

endmodule

//--- ramIfPortUnit.f
design/ramIfPortPkg.sv
design/ufibPacketDecoder.sv
design/hyperBusSequencer.sv
design/readWordPacker.sv
design/ramIfPortUnit.sv
sim/hyperRamModel.sv
sim/ramIfPortUnitTb.sv

//--- sim/hyperRamModel.sv
//--------------------
// behavioral hyperram: 4096-word array, two register
// words, single/double latency on alternate transactions
//--------------------
module hyperRamModel
	import ramIfPortPkg::*;
(
	input  logic rstN,
	input  logic ck,
	input  logic csN,
	input  logic [7:0] dqWr,
	output logic [7:0] dqRd = 8'd0,
	output logic rwds = 1'b0
);

	logic [31:0] mem [0:4095];
	logic [31:0] regWord [0:1];
	logic [47:0] ca;
	logic [23:0] addr;
	logic [23:0] wordIdx;
	// long latency on the next transaction
	logic dbl = 1'b0;
	logic active = 1'b0;
	// ck edges seen since cs fell
	int edgeCnt;
	int latEdges;
	int k;
	int lane;

	// fill depends on every address bit
	initial begin
		for (int i = 0; i < 4096; i++) begin
			mem[i] = {8'h5A, i[11:0], ~i[11:0]};
		end
		regWord[0] = 32'h8F1F_0000;
		regWord[1] = 32'h0000_0001;
	end

	always @(csN or ck) begin
		if (csN || !rstN) begin
			// alternate latency per transaction
			if (active) begin
				dbl = ~dbl;
			end
			active = 1'b0;
		end else if (!active) begin
			// cs just fell, rwds during CA picks the latency
			active = 1'b1;
			edgeCnt = 0;
			latEdges = dbl ? 12 : 6;
			rwds = dbl;
		end else begin
			edgeCnt = edgeCnt + 1;
			if (edgeCnt <= 6) begin
				ca = {ca[39:0], dqWr};
				addr = {ca[caRowLo+20:caRowLo], ca[caColHi:0]};
			end else if (edgeCnt == 7) begin
				rwds = 1'b0;
			end
			if (edgeCnt > 6 + latEdges) begin
				k = edgeCnt - 7 - latEdges;
				// wrapped bursts walk linearly in this model
				wordIdx = addr + 24'(k / 4);
				lane = 3 - k % 4;
				if (ca[caRdWrBit]) begin
					dqRd = ca[caAsBit] ? regWord[wordIdx[0]][8*lane +: 8]
						: mem[wordIdx[11:0]][8*lane +: 8];
					rwds = ~rwds;
				end else if (ca[caAsBit]) begin
					regWord[wordIdx[0]][8*lane +: 8] = dqWr;
				end else begin
					mem[wordIdx[11:0]][8*lane +: 8] = dqWr;
				end
			end
		end
	end

endmodule

//--- sim/ramIfPortPatterns.txt
// columns: kind (1 digit), count (2 digits), word (8 digits)
// kind 1 header, 2 write words, 3 expected read words, 4 wait for cs high, 0 end
// words of a series after the first add 01010101
// linear write of 4 words at 0x10, single latency
10024000010
20411223344
40000000000
// read back, double latency
100A4000010
30411223344
// register write to reg word 0
10061000010
2018F1F0055
40000000000
// register read, then array word at the same address
100E1000010
3018F1F0055
100A1000010
30111223344
// 31-word write with idle gaps, then read back
1003F000100
21FA0B1C2D3
40000000000
100BF000100
31FA0B1C2D3
// wrapped read of 8 words from 0x104
10088000104
308A4B5C6D7
00000000000

//--- sim/ramIfPortUnitTb.sv
//--------------------
// testbench: pattern-driven ufib packets into the port unit,
// read word checks, rdVd count, watchdog
//--------------------
module ramIfPortUnitTb
	import ramIfPortPkg::*;
();

	localparam int clkPeriod = 100;
	localparam int driveDly = 10;
	localparam int patDepth = 64;
	// each further word of a series adds this
	localparam logic [31:0] wordStep = 32'h0101_0101;

	logic clk;
	logic arstN;
	ufibWordU wd;
	logic wdVd;
	logic wdRdy;
	logic [31:0] rd;
	logic rdVd;
	logic [7:0] dqOut;
	logic [7:0] dqIn;
	logic dqOe;
	logic rwdsOut;
	logic rwdsIn;
	logic rwdsOe;
	logic ckP;
	logic ckN;
	logic csN;
	logic ramRstN;

	// kind [43:40], count [39:32], word [31:0]
	logic [43:0] pat [0:patDepth-1];
	int seed;
	int errCnt = 0;
	int checkCnt = 0;
	int cycleCnt = 0;
	int cycleLimit = 0;
	int rdPulseCnt = 0;
	int rdExpCnt = 0;
	logic readIssued = 1'b0;

	ramIfPortUnit #(
		.pRamDqWidth(8),
		.pLatencyClocks(6)
	) uut (
		.clk(clk),
		.arstN(arstN),
		.wd(wd),
		.wdVd(wdVd),
		.wdRdy(wdRdy),
		.rd(rd),
		.rdVd(rdVd),
		.dqOut(dqOut),
		.dqIn(dqIn),
		.dqOe(dqOe),
		.rwdsOut(rwdsOut),
		.rwdsIn(rwdsIn),
		.rwdsOe(rwdsOe),
		.ckP(ckP),
		.ckN(ckN),
		.csN(csN),
		.ramRstN(ramRstN)
	);

	hyperRamModel uRam (
		.rstN(ramRstN),
		.ck(ckP),
		.csN(csN),
		.dqWr(dqOut),
		.dqRd(dqIn),
		.rwds(rwdsIn)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// inputs change and outputs are read here
	task stepClock;
		@(posedge clk);
		#driveDly;
	endtask

	task checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCnt++;
		if (got !== exp) begin
			errCnt++;
			$display("[FAIL] time %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task sendWord(input logic [31:0] w, input logic isData);
		int gap;
		wd.data = w;
		// idle gaps only inside write bursts
		if (isData) begin
			// gap counted once the DUT is ready so ck stalls
			while (!wdRdy) begin
				stepClock;
			end
			gap = $random(seed) & 3;
			repeat (gap) stepClock;
		end
		wdVd = 1'b1;
		while (!wdRdy) begin
			stepClock;
		end
		stepClock;
		wdVd = 1'b0;
	endtask

	task expectWords(input int n, input logic [31:0] first);
		logic [31:0] expWord;
		expWord = first;
		repeat (n) begin
			stepClock;
			while (!rdVd) begin
				stepClock;
			end
			checkValue("rd", rd, expWord);
			expWord = expWord + wordStep;
		end
		// cs is back high by the time the last word shows up
		checkValue("csN", csN, 1);
	endtask

	task waitBusIdle;
		while (!csN) begin
			stepClock;
		end
		checkValue("dqOe", dqOe, 0);
		checkValue("rwdsOe", rwdsOe, 0);
	endtask

	// rdVd pulse count, and none before the first read
	always @(negedge clk) begin
		if (rdVd) begin
			rdPulseCnt++;
			if (!readIssued) begin
				errCnt++;
				$display("rdVd pulsed at %0t before any read request was sent", $time);
			end
		end
		// write bytes go out unmasked
		if (rwdsOe) begin
			checkValue("rwdsOut", rwdsOut, 0);
		end
	end

	initial begin
		cycleCnt = 0;
		wait (cycleLimit != 0);
		while (cycleCnt < cycleLimit) begin
			@(posedge clk);
			cycleCnt++;
		end
		$display("timeout: run still busy after %0d cycles", cycleLimit);
		$display("checks %0d, errors %0d", checkCnt, errCnt);
		$display("Verification failed");
		$finish;
	end

	initial begin
		int idx;
		int testWords;
		logic [3:0] kind;
		logic [7:0] cnt;
		logic [31:0] word;
		ufibWordU hdrWord;
		seed = 44;
		arstN = 1'b0;
		wd = '0;
		wdVd = 1'b0;
		$readmemh("sim/ramIfPortPatterns.txt", pat);
		// limit from the number of words the file lists
		idx = 0;
		testWords = 0;
		while (idx < patDepth && pat[idx][43:40] != 4'd0) begin
			if (pat[idx][43:40] == 4'd2 || pat[idx][43:40] == 4'd3) begin
				testWords += int'(pat[idx][39:32]);
			end else begin
				testWords += 1;
			end
			if (pat[idx][43:40] == 4'd3) begin
				rdExpCnt += int'(pat[idx][39:32]);
			end
			idx++;
		end
		if (testWords == 0) begin
			errCnt++;
			$display("pattern file missing or empty");
		end
		cycleLimit = 40 * testWords + 40;
		repeat (8) stepClock;
		// pins held in reset
		checkValue("csN", csN, 1);
		checkValue("dqOe", dqOe, 0);
		checkValue("rwdsOe", rwdsOe, 0);
		checkValue("ckP", ckP, 0);
		checkValue("ckN", ckN, 1);
		checkValue("ramRstN", ramRstN, 0);
		arstN = 1'b1;
		checkValue("wdRdy", wdRdy, 0);
		stepClock;
		checkValue("wdRdy", wdRdy, 1);
		checkValue("ramRstN", ramRstN, 0);
		stepClock;
		checkValue("ramRstN", ramRstN, 1);
		idx = 0;
		while (idx < patDepth && pat[idx][43:40] != 4'd0) begin
			kind = pat[idx][43:40];
			cnt = pat[idx][39:32];
			word = pat[idx][31:0];
			case (kind)
				4'd1: begin
					hdrWord = word;
					if (hdrWord.hdr.rdWr) begin
						readIssued = 1'b1;
					end
					sendWord(word, 1'b0);
				end
				4'd2: begin
					for (int n = 0; n < int'(cnt); n++) begin
						sendWord(word + n * wordStep, 1'b1);
					end
				end
				4'd3: expectWords(int'(cnt), word);
				4'd4: waitBusIdle;
				default: begin
					errCnt++;
					$display("unknown pattern kind %h on entry %0d", kind, idx);
				end
			endcase
			idx++;
		end
		// catch stray read words
		repeat (16) stepClock;
		checkValue("rdVd count", rdPulseCnt, rdExpCnt);
		$display("checks %0d, errors %0d", checkCnt, errCnt);
		if (errCnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
